/* pipe_trace_top.f */
src/trace_pkg.sv
src/trace_stage_fsm.sv
src/trace_counters.sv
src/trace_slot_store.sv
src/trace_retire_fmt.sv
src/pipe_trace_top.sv
tb/pipe_trace_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the trace unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module pipe_trace_tb \
  -f pipe_trace_top.f > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vpipe_trace_tb > sim.log 2>&1 || { cat sim.log; echo "simulator error"; exit 1; }
cat sim.log
grep -q "=== FAIL ===" sim.log && { echo "simulation failed"; exit 1; } || exit 0

/* tb/pipe_trace_tb.sv */
`timescale 1ns/1ps

module pipe_trace_tb;
  import trace_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int RST_CYCLES = 10;
  localparam int DB_DEPTH   = 256;   // Circular record store, far deeper than the pipe
  localparam int RAND_N     = 120;   // Instructions in the random stream
  // Cycle budgets per test, watchdog is their sum plus margin
  localparam int WD_CYCLES  = RST_CYCLES + 20 + (RST_CYCLES + 30) + 60 + 20
                              + (2 * RST_CYCLES + 30) + RAND_N * 8 + 200;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        stall;
  fetch_ev_t   fetch;
  stage_data_t data;
  logic        retire_valid;
  retire_rec_t retire;

  // Reference model state, -1 marks an empty stage
  retire_rec_t      rec_db [DB_DEPTH];
  retire_rec_t      exp_q  [$];           // Expected retire records
  retire_rec_t      last_got;             // Last record seen on the output
  logic [31:0]      word_q [$];           // Directed instruction words
  int               st_f, st_d, st_e, st_m, st_w;
  int               de_last;              // Id shown in decode last cycle
  int               n_ids;                // Accepted fetches, never cleared
  logic [SEQ_W-1:0] mseq;
  logic [CYC_W-1:0] mcyc;                 // Cycle stamp the DUT holds now
  logic             cur_fv, cur_stall;    // Inputs seen at the next edge
  logic [31:0]      cur_pc;
  int               errors, err_at_start, n_pass, n_fail;

  pipe_trace_top i_pipe_trace_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .stall        (stall),
    .fetch        (fetch),
    .data         (data),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////////////////
  // Expected values
  ////////////////////////////////////////////////////////////////////////
  // Operand fields straight from the RISC-V bit positions
  function automatic retire_rec_t finish_rec(retire_rec_t r);
    logic [31:0] w;
    w     = r.instr;
    r.rd  = w[11:7];
    r.rs1 = w[19:15];
    if (w[6:0] == 7'b0110011) begin
      r.src2   = {27'd0, w[24:20]};        // rs2 index
      r.is_imm = 1'b0;
    end else begin
      r.src2   = {{20{w[31]}}, w[31:20]};  // Sign-extended imm12
      r.is_imm = 1'b1;
    end
    return r;
  endfunction

  // Random word, half of them register-register
  function automatic logic [31:0] rand_word();
    logic [31:0] w;
    w = $urandom;
    if ($urandom % 2 == 0) w[6:0] = 7'b0110011;
    return w;
  endfunction

  function automatic logic busy();
    return (st_f >= 0) || (st_d >= 0) || (st_e >= 0) || (st_m >= 0) || (st_w >= 0)
           || cur_fv;
  endfunction

  task automatic model_clear();
    st_f = -1;
    st_d = -1;
    st_e = -1;
    st_m = -1;
    st_w = -1;
    de_last = -1;
    exp_q.delete();
    mseq = '0;
    mcyc = '0;
    cur_fv = 1'b0;
    cur_stall = 1'b0;
    cur_pc = '0;
  endtask

  // One clock edge of the model, using the inputs driven before it
  task automatic advance(output logic exp_ret);
    int id;
    exp_ret = 1'b0;
    if (st_w >= 0) begin
      rec_db[st_w].retire_cycle = mcyc;
      exp_q.push_back(finish_rec(rec_db[st_w]));
      exp_ret = 1'b1;
    end
    st_w = st_m;
    st_m = st_e;                           // Back end always moves
    if (cur_stall) begin
      st_e = -1;                           // Bubble into execute
    end else begin
      st_e = st_d;
      st_d = st_f;
      st_f = -1;
    end
    if (cur_fv && !cur_stall) begin
      id = n_ids % DB_DEPTH;
      n_ids++;
      rec_db[id] = '0;
      rec_db[id].seq = mseq;
      rec_db[id].fetch_cycle = mcyc;
      rec_db[id].pc = cur_pc;
      if (word_q.size() > 0) rec_db[id].instr = word_q.pop_front();
      else                   rec_db[id].instr = rand_word();
      st_f = id;
      mseq++;
    end
    mcyc++;
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////
  task automatic field_check(string name, logic [31:0] exp, logic [31:0] got);
    if (exp !== got) begin
      $display("ERR %s exp=%h got=%h", name, exp, got);
      errors++;
    end
  endtask

  task automatic compare_rec(retire_rec_t exp, retire_rec_t got);
    field_check("retire.seq", 32'(exp.seq), 32'(got.seq));
    field_check("retire.fetch_cycle", 32'(exp.fetch_cycle), 32'(got.fetch_cycle));
    field_check("retire.retire_cycle", 32'(exp.retire_cycle), 32'(got.retire_cycle));
    field_check("retire.pc", exp.pc, got.pc);
    field_check("retire.instr", exp.instr, got.instr);
    field_check("retire.rd", 32'(exp.rd), 32'(got.rd));
    field_check("retire.rs1", 32'(exp.rs1), 32'(got.rs1));
    field_check("retire.src2", exp.src2, got.src2);
    field_check("retire.is_imm", 32'(exp.is_imm), 32'(got.is_imm));
    field_check("retire.ex_result", exp.ex_result, got.ex_result);
    field_check("retire.mem_addr", exp.mem_addr, got.mem_addr);
    field_check("retire.wb_data", exp.wb_data, got.wb_data);
  endtask

  task automatic compare_strobe(logic exp, logic got);
    if (exp !== got) begin
      if (exp) $display("Expected retire strobe missing at model cycle %0d", mcyc);
      else     $display("Unexpected retire strobe at model cycle %0d", mcyc);
      errors++;
    end
  endtask

  task automatic compare_cyc(string name, logic [CYC_W-1:0] exp, logic [CYC_W-1:0] got);
    if (exp !== got) begin
      $display("ERR %s exp=%h got=%h", name, exp, got);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////
  // Edge, model update, drive payloads for the new stage contents, check at negedge
  task automatic step(input logic fv, input logic st);
    logic [31:0] w;
    logic [31:0] v;
    logic        exp_ret;
    retire_rec_t exp;
    @(posedge clk);
    advance(exp_ret);
    w = rand_word();
    if (st_d >= 0) begin
      if (st_d == de_last) rec_db[st_d].instr = w;  // Re-presented under stall
      else                 w = rec_db[st_d].instr;
    end
    de_last = st_d;
    data.id_instr <= w;
    v = $urandom;
    if (st_e >= 0) rec_db[st_e].ex_result = v;
    data.ex_result <= v;
    v = $urandom;
    if (st_m >= 0) rec_db[st_m].mem_addr = v;
    data.mem_addr <= v;
    v = $urandom;
    if (st_w >= 0) rec_db[st_w].wb_data = v;
    data.wb_data <= v;
    cur_pc = $urandom & 32'hffff_fffc;    // Word-aligned pc
    cur_fv = fv;
    cur_stall = st;
    fetch.valid <= fv;
    fetch.pc <= cur_pc;
    stall <= st;
    @(negedge clk);
    compare_strobe(exp_ret, retire_valid);
    if (exp_ret) begin
      exp = exp_q.pop_front();
      if (retire_valid) begin
        compare_rec(exp, retire);
        last_got = retire;
      end
    end
  endtask

  task automatic drain();
    while (busy()) step(1'b0, 1'b0);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst_n <= 1'b0;
    stall <= 1'b0;
    fetch <= '0;
    data <= '0;
    model_clear();
    repeat (RST_CYCLES) begin
      @(negedge clk);
      compare_strobe(1'b0, retire_valid);  // Nothing retires inside reset
    end
    @(posedge clk);
    rst_n <= 1'b1;
  endtask

  task automatic start_test();
    err_at_start = errors;
  endtask

  task automatic end_test(string name);
    if (errors == err_at_start) begin
      n_pass++;
      $display("test %s ok", name);
    end else begin
      n_fail++;
      $display("test %s failed with %0d errors", name, errors - err_at_start);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////
  task automatic test_single();
    start_test();
    step(1'b1, 1'b0);
    drain();
    compare_cyc("latency", CYC_W'(5), last_got.retire_cycle - last_got.fetch_cycle);
    end_test("single");
  endtask

  // Fresh reset so seq counts from 0
  task automatic test_stream();
    start_test();
    apply_reset();
    repeat (8) step(1'b1, 1'b0);
    drain();
    end_test("stream");
  endtask

  task automatic test_stall();
    int lens [4] = '{3, 1, 5, 2};
    start_test();
    foreach (lens[k]) begin
      step(1'b1, 1'b0);
      step(1'b1, 1'b0);
      repeat (lens[k]) step(1'b1, 1'b1);   // Fetch held against the stall
    end
    drain();
    end_test("stall");
  endtask

  task automatic test_union();
    start_test();
    word_q.push_back({7'b0100000, 5'd13, 5'd7, 3'd0, 5'd3, 7'b0110011});  // sub x3,x7,x13
    word_q.push_back({12'hffb, 5'd9, 3'd0, 5'd17, 7'b0010011});           // addi x17,x9,-5
    step(1'b1, 1'b0);
    step(1'b1, 1'b0);
    drain();
    end_test("union");
  endtask

  task automatic test_reset();
    start_test();
    repeat (3) step(1'b1, 1'b0);
    apply_reset();                          // Three instructions dropped mid-flight
    repeat (3) step(1'b0, 1'b0);
    step(1'b1, 1'b0);
    drain();
    compare_cyc("seq after reset", '0, CYC_W'(last_got.seq));
    end_test("reset");
  endtask

  task automatic test_random();
    int target;
    start_test();
    target = n_ids + RAND_N;
    while (n_ids < target) step(($urandom % 4) != 0, ($urandom % 5) == 0);
    drain();
    end_test("random");
  endtask

  initial begin
    rst_n = 1'b0;
    stall = 1'b0;
    fetch = '0;
    data = '0;
    errors = 0;
    n_pass = 0;
    n_fail = 0;
    n_ids = 0;
    last_got = '0;
    void'($urandom(25));
    apply_reset();
    test_single();
    test_stream();
    test_stall();
    test_union();
    test_reset();
    test_random();
    $display("tests passed %0d, failed %0d, errors %0d", n_pass, n_fail, errors);
    if (n_fail == 0 && errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

  // Watchdog
  initial begin
    #(WD_CYCLES * CLK_PERIOD);
    $display("Watchdog expired, tests did not finish within %0d cycles", WD_CYCLES);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

/* src/pipe_trace_top.sv */
`timescale 1ns/1ps

module pipe_trace_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   stall,         // Fetch and decode hold
  input  trace_pkg::fetch_ev_t   fetch,
  input  trace_pkg::stage_data_t data,
  output logic                   retire_valid,
  output trace_pkg::retire_rec_t retire
);
  import trace_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Internal wiring
  //////////////////////////////////////////////////////////////////////
  logic              fetch_accept;  // Fetch taken this edge
  logic [SLOT_W-1:0] alloc_slot;    // Slot given to it
  stage_map_t        map;           // Which slot sits in each stage
  logic [CYC_W-1:0]  cycle;
  logic [SEQ_W-1:0]  seq;
  slot_rec_t         wb_rec;        // Record of the writeback slot

  // Slot stage tracking and allocation
  trace_stage_fsm i_trace_stage_fsm (
    .clk          (clk),
    .rst_n        (rst_n),
    .stall        (stall),
    .fetch_valid  (fetch.valid),
    .fetch_accept (fetch_accept),
    .alloc_slot   (alloc_slot),
    .map          (map)
  );

  // Cycle and sequence stamps
  trace_counters i_trace_counters (
    .clk          (clk),
    .rst_n        (rst_n),
    .fetch_accept (fetch_accept),
    .cycle        (cycle),
    .seq          (seq)
  );

  // Per-slot payload capture
  trace_slot_store i_trace_slot_store (
    .clk          (clk),
    .rst_n        (rst_n),
    .stall        (stall),
    .fetch_accept (fetch_accept),
    .alloc_slot   (alloc_slot),
    .pc           (fetch.pc),
    .seq          (seq),
    .cycle        (cycle),
    .map          (map),
    .data         (data),
    .wb_rec       (wb_rec)
  );

  // Retire record out
  trace_retire_fmt i_trace_retire_fmt (
    .clk          (clk),
    .rst_n        (rst_n),
    .wb_vld       (map.wb.vld),
    .wb_rec       (wb_rec),
    .wb_data      (data.wb_data),
    .cycle        (cycle),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

endmodule

/* src/trace_retire_fmt.sv */
`timescale 1ns/1ps

module trace_retire_fmt (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        wb_vld,        // Writeback stage occupied
  input  trace_pkg::slot_rec_t        wb_rec,
  input  logic [31:0]                 wb_data,
  input  logic [trace_pkg::CYC_W-1:0] cycle,
  output logic                        retire_valid,
  output trace_pkg::retire_rec_t      retire
);
  import trace_pkg::*;

  retire_rec_t rec_d;  // Record as it will be registered
  logic        is_rr;  // Register-register opcode

  //////////////////////////////////////////////////////////////////////
  // Record build and operand decode
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    is_rr = (wb_rec.instr.r.opcode == OPC_RR);

    rec_d.seq          = wb_rec.seq;
    rec_d.fetch_cycle  = wb_rec.fetch_cycle;
    rec_d.retire_cycle = cycle;             // Stamp of the retiring edge
    rec_d.pc           = wb_rec.pc;
    rec_d.instr        = wb_rec.instr;
    rec_d.rd           = wb_rec.instr.r.rd; // Same bits in both views
    rec_d.rs1          = wb_rec.instr.i.rs1;
    rec_d.ex_result    = wb_rec.ex_result;
    rec_d.mem_addr     = wb_rec.mem_addr;
    rec_d.wb_data      = wb_data;

    if (is_rr) begin
      rec_d.src2   = {27'd0, wb_rec.instr.r.rs2};  // Register index
      rec_d.is_imm = 1'b0;
    end else begin
      // Anything else treated as I-type
      rec_d.src2   = {{20{wb_rec.instr.i.imm12[11]}}, wb_rec.instr.i.imm12};
      rec_d.is_imm = 1'b1;
    end
  end

  // One-cycle strobe after the writeback edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      retire_valid <= 1'b0;
    else
      retire_valid <= wb_vld;
  end

  always_ff @(posedge clk) begin
    if (wb_vld) retire <= rec_d;            // Held until the next retire
  end

endmodule

/* src/trace_slot_store.sv */
`timescale 1ns/1ps

module trace_slot_store (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         stall,
  input  logic                         fetch_accept,
  input  logic [trace_pkg::SLOT_W-1:0] alloc_slot,
  input  logic [31:0]                  pc,
  input  logic [trace_pkg::SEQ_W-1:0]  seq,
  input  logic [trace_pkg::CYC_W-1:0]  cycle,
  input  trace_pkg::stage_map_t        map,
  input  trace_pkg::stage_data_t       data,
  output trace_pkg::slot_rec_t         wb_rec
);
  import trace_pkg::*;

  slot_rec_t            slots [NUM_SLOTS];  // One record per tracking slot
  logic [NUM_SLOTS-1:0] alloc_we;           // Allocation write
  logic [NUM_SLOTS-1:0] de_we;              // Slot leaving decode
  logic [NUM_SLOTS-1:0] ex_we;              // Slot leaving execute
  logic [NUM_SLOTS-1:0] mem_we;             // Slot leaving memory

  //////////////////////////////////////////////////////////////////////
  // Write strobes
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    for (int i = 0; i < NUM_SLOTS; i++) begin
      alloc_we[i] = fetch_accept && (alloc_slot == SLOT_W'(i));
      // Decode word taken only on the edge that releases decode
      de_we[i]    = map.de.vld && !stall && (map.de.slot == SLOT_W'(i));
      ex_we[i]    = map.ex.vld && (map.ex.slot == SLOT_W'(i));
      mem_we[i]   = map.mem.vld && (map.mem.slot == SLOT_W'(i));
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Slot registers, field by field
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_SLOTS; i++) begin
        slots[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_SLOTS; i++) begin
        if (alloc_we[i]) begin
          slots[i].seq         <= seq;      // Pre-increment value
          slots[i].fetch_cycle <= cycle;
          slots[i].pc          <= pc;
        end
        if (de_we[i])
          slots[i].instr     <= data.id_instr;
        if (ex_we[i])
          slots[i].ex_result <= data.ex_result;
        if (mem_we[i])
          slots[i].mem_addr  <= data.mem_addr;
      end
    end
  end

  // Writeback slot read out, old contents still visible on reuse edge
  always_comb begin
    wb_rec = '0;
    for (int i = 0; i < NUM_SLOTS; i++) begin
      if (map.wb.slot == SLOT_W'(i)) wb_rec = slots[i];
    end
  end

endmodule

/* src/trace_counters.sv */
`timescale 1ns/1ps

module trace_counters (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        fetch_accept,  // One per accepted fetch
  output logic [trace_pkg::CYC_W-1:0] cycle,
  output logic [trace_pkg::SEQ_W-1:0] seq
);
  import trace_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Free-running cycle stamp
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      cycle <= '0;
    else
      cycle <= cycle + 1'b1;                // Wraps at 2**CYC_W
  end

  //////////////////////////////////////////////////////////////////////
  // Program order number
  //////////////////////////////////////////////////////////////////////
  // Slot takes the current value, counter moves on at the same edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      seq <= '0;
    else if (fetch_accept)
      seq <= seq + 1'b1;
  end

endmodule

/* src/trace_stage_fsm.sv */
`timescale 1ns/1ps

module trace_stage_fsm (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         stall,         // Holds fetch and decode
  input  logic                         fetch_valid,
  output logic                         fetch_accept,
  output logic [trace_pkg::SLOT_W-1:0] alloc_slot,
  output trace_pkg::stage_map_t        map
);
  import trace_pkg::*;

  stage_t               slot_st  [NUM_SLOTS];  // Current stage per slot
  stage_t               slot_nxt [NUM_SLOTS];  // Stage after this edge, before allocation
  logic [NUM_SLOTS-1:0] slot_free;             // Empty now or leaving writeback

  //////////////////////////////////////////////////////////////////////
  // Next stage per slot
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    for (int i = 0; i < NUM_SLOTS; i++) begin
      case (slot_st[i])
        FETCH: begin
          if (stall) slot_nxt[i] = FETCH;     // Front end held
          else       slot_nxt[i] = DECODE;
        end
        DECODE: begin
          if (stall) slot_nxt[i] = DECODE;
          else       slot_nxt[i] = EXECUTE;
        end
        EXECUTE: slot_nxt[i] = MEMORY;        // Back end never stalls
        MEMORY:  slot_nxt[i] = WRITEBACK;
        default: slot_nxt[i] = EMPTY;         // Writeback retires, empty stays empty
      endcase
      slot_free[i] = (slot_st[i] == EMPTY) || (slot_st[i] == WRITEBACK);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Allocation, lowest free slot wins
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    alloc_slot = '0;
    // Walk downward so the last hit is the lowest index
    for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
      if (slot_free[i]) alloc_slot = SLOT_W'(i);
    end
  end

  // One instruction per stage, so a moving front end always finds a free slot
  assign fetch_accept = fetch_valid & ~stall;

  // Stage registers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_SLOTS; i++) begin
        slot_st[i] <= EMPTY;
      end
    end else begin
      for (int i = 0; i < NUM_SLOTS; i++) begin
        if (fetch_accept && (alloc_slot == SLOT_W'(i)))
          slot_st[i] <= FETCH;              // New instruction lands here
        else
          slot_st[i] <= slot_nxt[i];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stage to slot map
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    map = '0;
    for (int i = 0; i < NUM_SLOTS; i++) begin
      case (slot_st[i])
        DECODE: begin
          map.de.vld  = 1'b1;
          map.de.slot = SLOT_W'(i);
        end
        EXECUTE: begin
          map.ex.vld  = 1'b1;
          map.ex.slot = SLOT_W'(i);
        end
        MEMORY: begin
          map.mem.vld  = 1'b1;
          map.mem.slot = SLOT_W'(i);
        end
        WRITEBACK: begin
          map.wb.vld  = 1'b1;
          map.wb.slot = SLOT_W'(i);
        end
        default: ;                          // Fetch and empty slots not mapped
      endcase
    end
  end

endmodule

/* src/trace_pkg.sv */
package trace_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////////////////////////
  localparam int NUM_SLOTS = 5;   // One slot per pipeline stage
  localparam int SLOT_W    = 3;   // Slot index width
  localparam int CYC_W     = 16;  // Cycle stamp width, wraps
  localparam int SEQ_W     = 8;   // Program order number width

  localparam logic [6:0] OPC_RR = 7'b0110011;  // Register-register ALU ops

  // Stage a slot currently sits in
  typedef enum logic [2:0] {
    EMPTY,
    FETCH,
    DECODE,
    EXECUTE,
    MEMORY,
    WRITEBACK
  } stage_t;

  //////////////////////////////////////////////////////////////////////
  // Instruction word, R-type and I-type views of the same 32 bits
  //////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } instr_r_t;

  typedef struct packed {
    logic [11:0] imm12;  // Signed immediate
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } instr_i_t;

  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_u;

  // Fetch strobe from the core
  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
  } fetch_ev_t;

  // Payloads for whatever sits in decode, execute, memory, writeback
  typedef struct packed {
    instr_u      id_instr;
    logic [31:0] ex_result;
    logic [31:0] mem_addr;
    logic [31:0] wb_data;
  } stage_data_t;

  // Occupancy of one stage
  typedef struct packed {
    logic              vld;
    logic [SLOT_W-1:0] slot;
  } stage_loc_t;

  typedef struct packed {
    stage_loc_t de;
    stage_loc_t ex;
    stage_loc_t mem;
    stage_loc_t wb;
  } stage_map_t;

  // Everything captured for one instruction before writeback
  typedef struct packed {
    logic [SEQ_W-1:0] seq;
    logic [CYC_W-1:0] fetch_cycle;
    logic [31:0]      pc;
    instr_u           instr;
    logic [31:0]      ex_result;
    logic [31:0]      mem_addr;
  } slot_rec_t;

  // Record emitted on retire
  typedef struct packed {
    logic [SEQ_W-1:0] seq;
    logic [CYC_W-1:0] fetch_cycle;
    logic [CYC_W-1:0] retire_cycle;
    logic [31:0]      pc;
    instr_u           instr;
    logic [4:0]       rd;
    logic [4:0]       rs1;
    logic [31:0]      src2;      // rs2 index or sign-extended imm12
    logic             is_imm;
    logic [31:0]      ex_result;
    logic [31:0]      mem_addr;
    logic [31:0]      wb_data;
  } retire_rec_t;

endpackage
